/* fabric_tile.f */
+incdir+bench
src/fabric_pkg.sv
src/config_loader.sv
src/logic_block.sv
src/switch_box.sv
src/fabric_tile.sv
bench/tile_tb.sv

/* Makefile */
# Verilator build and run for the fabric tile testbench.
# Any variable below can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tile_tb
FILELIST  ?= fabric_tile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** PASSED ***

SOURCES   := $(wildcard src/*.sv bench/*.sv bench/*.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run counts as passed only if the log holds the pass message.
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tile_model.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fabric tile reference model. Expected lookup result and outgoing
// tracks, computed from shadow copies of both configurations.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TILE_MODEL_SVH
`define TILE_MODEL_SVH

// Track t of side s, side 0 in the low nibble.
function automatic logic track_bit(input fabric_pkg::tracks_t tr,
                                   input logic [1:0] s, input logic [1:0] t);
   fabric_pkg::side_tracks_t side;
   case (s)
      2'd0:    side = tr.side_0;
      2'd1:    side = tr.side_1;
      2'd2:    side = tr.side_2;
      default: side = tr.side_3;
   endcase
   return side[t];
endfunction

// Input i reads the selected track of side i, input 0 is the index LSB.
function automatic logic lut_value(input fabric_pkg::clb_cfg_t cfg,
                                   input fabric_pkg::tracks_t tr);
   logic [3:0] idx;
   for (int i = 0; i < 4; i++) begin
      idx[i] = track_bit(tr, 2'(i), cfg.in_sel[i]);
   end
   return cfg.truth[idx];
endfunction

// Registered mode shows the value sampled at the last rising edge.
function automatic logic expected_result(input fabric_pkg::clb_cfg_t cfg,
                                         input fabric_pkg::tracks_t tr,
                                         input logic flop);
   return cfg.registered ? flop : lut_value(cfg, tr);
endfunction

// Select s on side s takes the result, any other v takes side v, same track.
function automatic fabric_pkg::tracks_t route_tracks(input fabric_pkg::sb_cfg_t cfg,
                                                     input fabric_pkg::tracks_t tr,
                                                     input logic result);
   logic [15:0][1:0] sel;
   logic [15:0]      out;
   sel = cfg;
   for (int s = 0; s < 4; s++) begin
      for (int t = 0; t < 4; t++) begin
         out[s*4+t] = (sel[s*4+t] == 2'(s)) ? result
                                            : track_bit(tr, sel[s*4+t], 2'(t));
      end
   end
   return fabric_pkg::tracks_t'(out);
endfunction

// Every outgoing track carries the logic block result.
function automatic fabric_pkg::sb_cfg_t result_everywhere();
   logic [15:0][1:0] sel;
   for (int s = 0; s < 4; s++) begin
      for (int t = 0; t < 4; t++) begin
         sel[s*4+t] = 2'(s);
      end
   end
   return fabric_pkg::sb_cfg_t'(sel);
endfunction

`endif

/* bench/tile_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fabric tile testbench. Loads configurations over the valid/ready port
// and checks routing, lookup and registered results against a model.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tile_tb;

   localparam int clk_half    = 10;             // 20 ns period.
   localparam int ready_limit = 20;             // Cycles to wait for cfg_ready.
   localparam int run_cycles  = 150;

   logic                  clk;
   logic                  rst;
   logic                  cfg_valid;
   fabric_pkg::cfg_word_t cfg_word;
   logic                  cfg_ready;
   logic                  configured;
   fabric_pkg::tracks_t   tracks_in = '0;
   fabric_pkg::tracks_t   tracks_out;

   fabric_pkg::sb_cfg_t   m_sb;                 // Shadow switch box config.
   fabric_pkg::clb_cfg_t  m_clb;                // Shadow logic block config.
   fabric_pkg::cfg_word_t m_word;               // Word held by the loader.
   logic                  m_pending;
   logic                  m_flop;               // Shadow lookup flop.
   logic                  m_sb_done;
   logic                  m_clb_done;
   logic                  check_en;
   int                    n_value_err;
   int                    n_port_err;
   int                    n_timeout;

   `include "tile_model.svh"

   fabric_tile DUT (
      .clk        (clk),
      .rst        (rst),
      .cfg_valid  (cfg_valid),
      .cfg_word   (cfg_word),
      .cfg_ready  (cfg_ready),
      .configured (configured),
      .tracks_in  (tracks_in),
      .tracks_out (tracks_out)
   );

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Model and comparison
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // A transfer at one edge is written into its block at the next edge.
   always @(posedge clk or negedge rst) begin
      if (!rst) begin
         m_sb       <= '0;
         m_clb      <= '0;
         m_word     <= '0;
         m_pending  <= 1'b0;
         m_flop     <= 1'b0;
         m_sb_done  <= 1'b0;
         m_clb_done <= 1'b0;
      end else begin
         m_flop <= lut_value(m_clb, tracks_in); // Old config, as the flop sees it.
         if (m_pending) begin
            if (m_word.target == fabric_pkg::cfg_logic) begin
               m_clb      <= m_word.payload.clb;
               m_clb_done <= 1'b1;
            end else begin
               m_sb      <= m_word.payload.sb;
               m_sb_done <= 1'b1;
            end
         end
         m_pending <= cfg_valid && !m_pending;
         if (cfg_valid && !m_pending) begin
            m_word <= cfg_word;
         end
      end
   end

   task automatic print_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
   endtask

   task automatic compare_outputs();
      fabric_pkg::tracks_t exp_tracks;
      logic                exp_configured;
      exp_tracks     = route_tracks(m_sb, tracks_in, expected_result(m_clb, tracks_in, m_flop));
      exp_configured = m_sb_done && m_clb_done;
      assert (tracks_out === exp_tracks) else begin
         n_value_err++;
         print_mismatch("tracks_out", 32'(tracks_out), 32'(exp_tracks));
      end
      assert (cfg_ready === !m_pending) else begin
         n_value_err++;
         print_mismatch("cfg_ready", 32'(cfg_ready), 32'(!m_pending));
      end
      assert (configured === exp_configured) else begin
         n_value_err++;
         print_mismatch("configured", 32'(configured), 32'(exp_configured));
      end
   endtask

   // Sample first, then drive the next random tracks.
   always @(negedge clk) begin
      if (check_en) begin
         compare_outputs();
      end
      tracks_in = fabric_pkg::tracks_t'($urandom);
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Drivers
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic apply_reset();
      check_en  = 1'b0;
      cfg_valid = 1'b0;
      rst       = 1'b0;
      repeat (2) @(negedge clk);
      rst      = 1'b1;
      check_en = 1'b1;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge clk);
   endtask

   function automatic fabric_pkg::cfg_word_t make_word(input fabric_pkg::cfg_target_e target,
                                                       input logic [31:0] bits);
      fabric_pkg::cfg_word_t w;
      w.target  = target;
      w.payload = fabric_pkg::cfg_payload_u'(bits);
      return w;
   endfunction

   // Called just after a falling edge; hold keeps cfg_valid up for a burst.
   task automatic send_word(input fabric_pkg::cfg_word_t w, input logic hold);
      int waited;
      waited    = 0;
      cfg_valid = 1'b1;
      cfg_word  = w;
      while (cfg_ready !== 1'b1 && waited < ready_limit) begin
         @(negedge clk);
         waited++;
      end
      assert (cfg_ready === 1'b1) else begin
         n_timeout++;
         $display("timeout at %0t: cfg_ready stayed low for %0d cycles", $time, ready_limit);
      end
      @(negedge clk);                           // Transfer on the edge in between.
      assert (cfg_ready === 1'b0) else begin
         n_port_err++;
         print_mismatch("cfg_ready", 32'(cfg_ready), 32'(1'b0));
      end
      if (!hold) begin
         cfg_valid = 1'b0;
      end
   endtask

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      fabric_pkg::clb_cfg_t lc;
      void'($urandom(35293));
      rst         = 1'b0;
      cfg_valid   = 1'b0;
      cfg_word    = '0;
      check_en    = 1'b0;
      n_value_err = 0;
      n_port_err  = 0;
      n_timeout   = 0;
      apply_reset();

      // Reset state: all zero routing, not configured, ready.
      idle(10);

      // Switch routing with a constant lookup result.
      for (int n = 0; n < 4; n++) begin
         lc            = fabric_pkg::clb_cfg_t'($urandom);
         lc.registered = 1'b0;
         lc.truth      = {16{lc.truth[0]}};
         send_word(make_word(fabric_pkg::cfg_switch, $urandom), 1'b0);
         send_word(make_word(fabric_pkg::cfg_logic, lc), 1'b0);
         idle(run_cycles / 4);
      end

      // Lookup function, combinational, routed to every track.
      send_word(make_word(fabric_pkg::cfg_switch, result_everywhere()), 1'b0);
      for (int n = 0; n < 4; n++) begin
         lc            = fabric_pkg::clb_cfg_t'($urandom);
         lc.registered = 1'b0;
         send_word(make_word(fabric_pkg::cfg_logic, lc), 1'b0);
         idle(run_cycles / 4);
      end

      // Registered mode.
      lc.registered = 1'b1;
      send_word(make_word(fabric_pkg::cfg_logic, lc), 1'b0);
      idle(run_cycles);

      // Burst with cfg_valid held; configured rises after both targets.
      apply_reset();
      send_word(make_word(fabric_pkg::cfg_switch, $urandom), 1'b1);
      send_word(make_word(fabric_pkg::cfg_switch, $urandom), 1'b1);
      send_word(make_word(fabric_pkg::cfg_logic, $urandom), 1'b1);
      send_word(make_word(fabric_pkg::cfg_switch, result_everywhere()), 1'b1);
      send_word(make_word(fabric_pkg::cfg_logic, $urandom), 1'b0);
      idle(run_cycles);

      $display("checks done: %0d value errors, %0d port errors, %0d timeouts",
               n_value_err, n_port_err, n_timeout);
      if (n_value_err == 0 && n_port_err == 0 && n_timeout == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* src/fabric_tile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fabric tile. Configuration loader, logic block and switch box of one
// island of the programmable fabric.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fabric_tile (
   input  logic                  clk,
   input  logic                  rst,

   // Configuration port.
   input  logic                  cfg_valid,
   input  fabric_pkg::cfg_word_t cfg_word,
   output logic                  cfg_ready,
   output logic                  configured,

   // Routing tracks.
   input  fabric_pkg::tracks_t   tracks_in,
   output fabric_pkg::tracks_t   tracks_out
);

   logic                     sb_cfg_en;         // Switch box write.
   logic                     clb_cfg_en;        // Logic block write.
   fabric_pkg::cfg_payload_u cfg_payload;       // Shared write data.
   logic                     clb_result;        // Lookup result to routing.

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Configuration
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   config_loader u_loader (
      .clk         (clk),
      .rst         (rst),
      .cfg_valid   (cfg_valid),
      .cfg_word    (cfg_word),
      .cfg_ready   (cfg_ready),
      .sb_cfg_en   (sb_cfg_en),
      .clb_cfg_en  (clb_cfg_en),
      .cfg_payload (cfg_payload),
      .configured  (configured)
   );

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Datapath
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // The lookup reads incoming tracks only, so routing has no loop.
   logic_block u_clb (
      .clk         (clk),
      .rst         (rst),
      .cfg_en      (clb_cfg_en),
      .cfg_payload (cfg_payload),
      .tracks_in   (tracks_in),
      .clb_result  (clb_result)
   );

   switch_box u_sb (
      .clk         (clk),
      .rst         (rst),
      .cfg_en      (sb_cfg_en),
      .cfg_payload (cfg_payload),
      .tracks_in   (tracks_in),
      .clb_result  (clb_result),
      .tracks_out  (tracks_out)
   );

endmodule

/* src/switch_box.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Switch box. Each outgoing track takes the same track of another side
// or the logic block result, as chosen by a 2-bit select.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

//               side 3
//
//   side 2    switch_box    side 0
//
//               side 1

module switch_box (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_en,
   input  fabric_pkg::cfg_payload_u cfg_payload,
   input  fabric_pkg::tracks_t      tracks_in,
   input  logic                     clb_result,
   output fabric_pkg::tracks_t      tracks_out
);

   fabric_pkg::sb_cfg_t  cfg_q;                 // Routing configuration.
   logic [3:0][3:0][1:0] sel;                   // Indexed [side][track].
   logic [3:0][3:0]      in_arr;                // Incoming [side][track].
   logic [3:0][3:0]      out_arr;               // Outgoing [side][track].

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Configuration register
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // 16 switches with 4 options each fill the 32-bit register.
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cfg_q <= '0;
      end else if (cfg_en) begin
         cfg_q <= cfg_payload.sb;
      end
   end

   assign sel    = cfg_q;                       // Side 3 track 3 is the top field.
   assign in_arr = tracks_in;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Track multiplexers
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // A select equal to the own side number picks the logic block,
   // which frees that slot since a side never feeds itself.
   for (genvar s = 0; s < 4; s++) begin : g_side
      localparam logic [1:0] own_side = 2'(s);

      for (genvar t = 0; t < 4; t++) begin : g_track
         assign out_arr[s][t] = (sel[s][t] == own_side) ? clb_result
                                                       : in_arr[sel[s][t]][t];
      end
   end

   assign tracks_out = out_arr;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Routing must stay fully defined for every cycle out of reset.
   a_cfg_known : assert property (
      @(posedge clk) disable iff (!rst)
      !$isunknown(cfg_q)
   ) else $error("switch_box: configuration register has unknown bits");

endmodule

/* src/logic_block.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Logic block. A 4-input lookup table fed by one track per side, with a
// combinational or registered result.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module logic_block (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_en,
   input  fabric_pkg::cfg_payload_u cfg_payload,
   input  fabric_pkg::tracks_t      tracks_in,
   output logic                     clb_result
);

   fabric_pkg::clb_cfg_t cfg_q;                 // Function configuration.
   logic [3:0][3:0]      in_arr;                // Incoming [side][track].
   logic [3:0]           lut_in;                // Lookup index.
   logic                 lut_val;               // Direct lookup value.
   logic                 lut_q;                 // Registered lookup value.

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Configuration register
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cfg_q <= '0;                           // Zero table gives result 0.
      end else if (cfg_en) begin
         cfg_q <= cfg_payload.clb;
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Lookup table
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign in_arr = tracks_in;

   // Input i only ever sees side i, so one select per input suffices.
   for (genvar i = 0; i < 4; i++) begin : g_input
      assign lut_in[i] = in_arr[i][cfg_q.in_sel[i]];
   end

   assign lut_val = cfg_q.truth[lut_in];

   // Samples every cycle so switching to registered mode is immediate.
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         lut_q <= 1'b0;
      end else begin
         lut_q <= lut_val;
      end
   end

   assign clb_result = cfg_q.registered ? lut_q : lut_val;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // The loader must present a clean word on the cycle it writes us.
   a_payload_known : assert property (
      @(posedge clk) disable iff (!rst)
      cfg_en |-> !$isunknown(cfg_payload)
   ) else $error("logic_block: payload has unknown bits during a write");

endmodule

/* src/config_loader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration loader. Takes words over a valid/ready port and writes
// each one into the switch box or the logic block.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module config_loader (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_valid,
   input  fabric_pkg::cfg_word_t    cfg_word,
   output logic                     cfg_ready,
   output logic                     sb_cfg_en,
   output logic                     clb_cfg_en,
   output fabric_pkg::cfg_payload_u cfg_payload,
   output logic                     configured
);

   fabric_pkg::cfg_word_t word_q;               // Last accepted word.
   logic                  accept;               // Transfer on this edge.
   logic                  pending;              // Word waiting for its write.
   logic                  sb_loaded;            // Switch box written once.
   logic                  clb_loaded;           // Logic block written once.

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Ready comes from state alone, one word every two cycles at most.
   assign cfg_ready = !pending;
   assign accept    = cfg_valid && cfg_ready;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pending <= 1'b0;
      end else begin
         pending <= accept;                     // High for one cycle only.
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         word_q <= cfg_word;
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Write decode
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign sb_cfg_en   = pending && (word_q.target == fabric_pkg::cfg_switch);
   assign clb_cfg_en  = pending && (word_q.target == fabric_pkg::cfg_logic);
   assign cfg_payload = word_q.payload;         // Both blocks see it.

   // Sticky flags, set on the edge where the block takes its word.
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         sb_loaded  <= 1'b0;
         clb_loaded <= 1'b0;
      end else begin
         sb_loaded  <= sb_loaded  || sb_cfg_en;
         clb_loaded <= clb_loaded || clb_cfg_en;
      end
   end

   assign configured = sb_loaded && clb_loaded;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // A word lands in exactly one block.
   a_one_target : assert property (
      @(posedge clk) disable iff (!rst)
      $past(accept) |-> $onehot({sb_cfg_en, clb_cfg_en})
   ) else $error("config_loader: accepted word not written to exactly one block");

   // Writes only follow a transfer on the edge before, and go where it asked.
   a_en_after_accept : assert property (
      @(posedge clk) disable iff (!rst)
      (sb_cfg_en || clb_cfg_en) |->
         $past(accept) && (clb_cfg_en == ($past(cfg_word.target) == fabric_pkg::cfg_logic))
   ) else $error("config_loader: write enable without a matching accepted word");

endmodule

/* src/fabric_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fabric tile types: tracks, block configurations and the 33-bit
// configuration word with its two payload views.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fabric_pkg;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Tracks
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [3:0] side_tracks_t;           // Bit n is track n.

   typedef struct packed {
      side_tracks_t side_3;                     // Top.
      side_tracks_t side_2;                     // Left.
      side_tracks_t side_1;                     // Bottom.
      side_tracks_t side_0;                     // Right.
   } tracks_t;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Block configurations
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // One select per outgoing track, side 0 track 0 in bits 1:0.
   typedef struct packed {
      logic [1:0] s3_t3;
      logic [1:0] s3_t2;
      logic [1:0] s3_t1;
      logic [1:0] s3_t0;
      logic [1:0] s2_t3;
      logic [1:0] s2_t2;
      logic [1:0] s2_t1;
      logic [1:0] s2_t0;
      logic [1:0] s1_t3;
      logic [1:0] s1_t2;
      logic [1:0] s1_t1;
      logic [1:0] s1_t0;
      logic [1:0] s0_t3;
      logic [1:0] s0_t2;
      logic [1:0] s0_t1;
      logic [1:0] s0_t0;
   } sb_cfg_t;

   typedef struct packed {
      logic [6:0]      reserved;
      logic            registered;              // Result taken from the flop.
      logic [3:0][1:0] in_sel;                  // Track of side i for input i.
      logic [15:0]     truth;                   // Input 0 is the index LSB.
   } clb_cfg_t;

   typedef union packed {
      sb_cfg_t  sb;
      clb_cfg_t clb;
   } cfg_payload_u;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Configuration word
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic {
      cfg_switch = 1'b0,
      cfg_logic  = 1'b1
   } cfg_target_e;

   typedef struct packed {
      cfg_target_e  target;
      cfg_payload_u payload;
   } cfg_word_t;

endpackage
